// File: verilog.f
logic/issue_pkg.sv
logic/issue_regfile.sv
logic/issue_scoreboard.sv
logic/issue_read_operands.sv
logic/issue_stage.sv
tests/tb_clk_gen.sv
tests/tb_issue_stage.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - logic/issue_pkg.sv
  - logic/issue_regfile.sv
  - logic/issue_scoreboard.sv
  - logic/issue_read_operands.sv
  - logic/issue_stage.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_issue_stage.sv

// File: tests/tb_issue_stage.sv
/*
 * Random-stimulus testbench for the issue stage
 * Program-order reference model for dispatch, operands, stalls and commit
 */
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;

  localparam int unsigned NUM_CYCLES  = 4000;
  localparam int unsigned DRAIN_LIMIT = 200;
  localparam logic [31:0] NEVER       = 32'hffff_ffff;

  // Model entry, one per accepted instruction
  typedef struct packed {
    issue_pkg::decoded_instr_t ins;
    logic [31:0]               res;
    issue_pkg::trans_id_t      tid;
    logic [31:0]               done_at;   // First cycle the result is visible
  } model_entry_t;

  // Writeback waiting to be returned by a unit
  typedef struct packed {
    issue_pkg::trans_id_t tid;
    logic [31:0]          data;
    logic [3:0]           delay;
  } pending_wb_t;

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      flush_i;
  issue_pkg::decoded_instr_t decoded_instr_i;
  logic                      decoded_instr_valid_i;
  logic                      decoded_instr_ack_o;
  logic                      sb_full_o;
  issue_pkg::fu_data_t       fu_data_o;
  logic                      alu_valid_o;
  logic                      lsu_valid_o;
  logic                      mul_valid_o;
  logic                      flu_ready_i;
  logic                      lsu_ready_i;
  issue_pkg::wb_t            wb_i;
  issue_pkg::commit_t        commit_o;
  logic                      commit_valid_o;
  logic                      commit_ack_i;
  logic                      stall_issue_o;

  // ------------------------------
  // Model state
  // ------------------------------
  model_entry_t         model_q [$];
  pending_wb_t          pend_q [$];
  logic [31:0]          arch [issue_pkg::NR_REGS];
  integer               seed;
  logic [31:0]          cyc;
  logic [31:0]          pc_cnt;
  int                   n_disp;        // Dispatched entries at the front of model_q
  int                   n_commits;
  issue_pkg::trans_id_t tail;
  logic                 issue_prev;    // Model expected an acknowledge last cycle
  logic                 flush_prev;

  tb_clk_gen i_tb_clk_gen (.clk_o(clk_i));

  issue_stage issue_stage_i (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .flush_i               (flush_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .sb_full_o             (sb_full_o),
    .fu_data_o             (fu_data_o),
    .alu_valid_o           (alu_valid_o),
    .lsu_valid_o           (lsu_valid_o),
    .mul_valid_o           (mul_valid_o),
    .flu_ready_i           (flu_ready_i),
    .lsu_ready_i           (lsu_ready_i),
    .wb_i                  (wb_i),
    .commit_o              (commit_o),
    .commit_valid_o        (commit_valid_o),
    .commit_ack_i          (commit_ack_i),
    .stall_issue_o         (stall_issue_o)
  );

  task automatic stop_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic mismatch_error(input string sig, input logic [31:0] expv,
                                input logic [31:0] actv);
    $display("ERR %0t %s expected %h actual %h", $time, sig, expv, actv);
    stop_run();
  endtask

  task automatic plain_error(input string what);
    $display("Failure at %0t: %s", $time, what);
    stop_run();
  endtask

  // Pulse pattern as {alu, lsu, mul}
  function automatic logic [2:0] fu_onehot(input issue_pkg::fu_t fu);
    case (fu)
      issue_pkg::FU_ALU: return 3'b100;
      issue_pkg::FU_LSU: return 3'b010;
      default:           return 3'b001;
    endcase
  endfunction

  // Youngest older writer of rs in program order, else the committed value
  function automatic logic [31:0] operand_value(input issue_pkg::reg_addr_t rs, input int pos);
    logic [31:0] v;
    v = arch[rs];
    for (int i = 0; i < pos; i++) begin
      if (model_q[i].ins.rd == rs) v = model_q[i].res;
    end
    return (rs == '0) ? 32'h0 : v;
  endfunction

  // Cycle at which the youngest older producer became visible, 0 if none
  function automatic logic [31:0] producer_done_at(input issue_pkg::reg_addr_t rs,
                                                   input int pos);
    logic [31:0] v;
    v = 32'h0;
    for (int i = 0; i < pos; i++) begin
      if ((rs != '0) && (model_q[i].ins.rd == rs)) v = model_q[i].done_at;
    end
    return v;
  endfunction

  // Small register range so hazards are frequent
  function automatic issue_pkg::decoded_instr_t random_instr();
    issue_pkg::decoded_instr_t d;
    logic [31:0] r;
    r         = $random(seed);
    d.pc      = pc_cnt;
    pc_cnt    = pc_cnt + 32'd4;
    d.fu      = (r[1:0] == 2'd3) ? issue_pkg::FU_ALU : issue_pkg::fu_t'(r[1:0]);
    d.op      = r[5:2];
    d.rs1     = {2'b00, r[7:6]};
    d.rs2     = {2'b00, r[9:8]};
    d.rd      = {2'b00, r[11:10]};
    d.use_imm = r[12];
    d.imm     = $random(seed);
    return d;
  endfunction

  // ------------------------------
  // One clock cycle of checks, model and drive
  // ------------------------------
  task automatic run_cycle(input bit gen);
    model_entry_t              e;
    issue_pkg::decoded_instr_t nxt;
    issue_pkg::wb_t            wb_nxt;
    logic [31:0]               r, exp_a, exp_b;
    logic                      disp, exp_cv, accept;
    logic                      exp_room, exp_full, exp_stall, exp_issue;
    logic                      v_nxt, fl_nxt, flu_nxt, lsu_nxt, ack_nxt;
    int                        pick;
    @(negedge clk_i);
    cyc = cyc + 1;
    exp_room = (model_q.size() < issue_pkg::NR_SB_ENTRIES);
    exp_full = (model_q.size() == issue_pkg::NR_SB_ENTRIES);
    assert (decoded_instr_ack_o == exp_room)
      else mismatch_error("decoded_instr_ack_o", exp_room, decoded_instr_ack_o);
    assert (sb_full_o == exp_full) else mismatch_error("sb_full_o", exp_full, sb_full_o);
    disp = alu_valid_o | lsu_valid_o | mul_valid_o;
    if (flush_prev) begin
      assert (!disp && !commit_valid_o) else plain_error("activity right after a flush");
    end
    // A pulse follows every acknowledge the model expected one cycle earlier
    assert (disp == issue_prev) else mismatch_error("fu valid pulse", issue_prev, disp);
    if (disp) begin
      assert (n_disp < model_q.size()) else plain_error("dispatch with nothing waiting");
      e = model_q[n_disp];
      assert ({alu_valid_o, lsu_valid_o, mul_valid_o} == fu_onehot(e.ins.fu))
        else mismatch_error("fu valid pulses", fu_onehot(e.ins.fu),
                            {alu_valid_o, lsu_valid_o, mul_valid_o});
      assert (fu_data_o.fu == e.ins.fu)
        else mismatch_error("fu_data_o.fu", e.ins.fu, fu_data_o.fu);
      assert (fu_data_o.trans_id == e.tid)
        else mismatch_error("fu_data_o.trans_id", e.tid, fu_data_o.trans_id);
      assert (fu_data_o.pc == e.ins.pc)
        else mismatch_error("fu_data_o.pc", e.ins.pc, fu_data_o.pc);
      assert (fu_data_o.op == e.ins.op)
        else mismatch_error("fu_data_o.op", e.ins.op, fu_data_o.op);
      assert (fu_data_o.imm == e.ins.imm)
        else mismatch_error("fu_data_o.imm", e.ins.imm, fu_data_o.imm);
      exp_a = operand_value(e.ins.rs1, n_disp);
      exp_b = e.ins.use_imm ? e.ins.imm : operand_value(e.ins.rs2, n_disp);
      assert (fu_data_o.operand_a == exp_a)
        else mismatch_error("fu_data_o.operand_a", exp_a, fu_data_o.operand_a);
      assert (fu_data_o.operand_b == exp_b)
        else mismatch_error("fu_data_o.operand_b", exp_b, fu_data_o.operand_b);
      r = $random(seed);
      pend_q.push_back('{tid: e.tid, data: e.res, delay: {1'b0, r[2:0]}});
      n_disp = n_disp + 1;
    end
    // Oldest waiting entry stalls on a flush, a busy unit or an open producer
    exp_stall = 1'b0;
    if (model_q.size() > n_disp) begin
      e         = model_q[n_disp];
      exp_stall = flush_i || !((e.ins.fu == issue_pkg::FU_LSU) ? lsu_ready_i : flu_ready_i) ||
                  (producer_done_at(e.ins.rs1, n_disp) > cyc) ||
                  (!e.ins.use_imm && (producer_done_at(e.ins.rs2, n_disp) > cyc));
    end
    exp_issue = (model_q.size() > n_disp) && !exp_stall;
    assert (stall_issue_o == exp_stall)
      else mismatch_error("stall_issue_o", exp_stall, stall_issue_o);
    exp_cv = (model_q.size() != 0) && (model_q[0].done_at <= cyc);
    assert (commit_valid_o == exp_cv)
      else mismatch_error("commit_valid_o", exp_cv, commit_valid_o);
    if (exp_cv) begin
      e = model_q[0];
      assert (commit_o.trans_id == e.tid)
        else mismatch_error("commit_o.trans_id", e.tid, commit_o.trans_id);
      assert (commit_o.pc == e.ins.pc)
        else mismatch_error("commit_o.pc", e.ins.pc, commit_o.pc);
      assert (commit_o.rd == e.ins.rd)
        else mismatch_error("commit_o.rd", e.ins.rd, commit_o.rd);
      assert (commit_o.result == e.res)
        else mismatch_error("commit_o.result", e.res, commit_o.result);
    end
    issue_prev = exp_issue;

    // Handshakes taking effect at the coming edge, commit still writes during a flush
    if (commit_valid_o && commit_ack_i) begin
      e = model_q.pop_front();
      if (e.ins.rd != '0) arch[e.ins.rd] = e.res;
      n_disp    = n_disp - 1;
      n_commits = n_commits + 1;
    end
    accept = decoded_instr_valid_i && decoded_instr_ack_o && !flush_i;
    if (accept) begin
      r = $random(seed);
      model_q.push_back('{ins: decoded_instr_i, res: r, tid: tail, done_at: NEVER});
      tail = tail + 1'b1;
    end
    if (flush_i) begin
      model_q.delete();
      pend_q.delete();
      n_disp = 0;
      tail   = '0;
    end
    flush_prev = flush_i;

    // First writeback whose delay ran out, others count down
    wb_nxt = '0;
    pick   = -1;
    foreach (pend_q[i]) begin
      if ((pend_q[i].delay == 0) && (pick < 0)) pick = i;
      else if (pend_q[i].delay != 0) pend_q[i].delay = pend_q[i].delay - 1'b1;
    end
    if (pick >= 0) begin
      wb_nxt.valid    = 1'b1;
      wb_nxt.trans_id = pend_q[pick].tid;
      wb_nxt.data     = pend_q[pick].data;
      // Driven next cycle, sampled the edge after
      foreach (model_q[i]) begin
        if (model_q[i].tid == pend_q[pick].tid) model_q[i].done_at = cyc + 2;
      end
      pend_q.delete(pick);
    end

    r   = $random(seed);
    nxt = decoded_instr_i;
    if (gen) begin
      v_nxt   = (r[1:0] != 2'd0);
      fl_nxt  = (r[7:2] == 6'd0);
      flu_nxt = (r[10:8] != 3'd0);
      lsu_nxt = (r[13:11] != 3'd0);
      ack_nxt = (r[15:14] != 2'd0);
      if (accept || !decoded_instr_valid_i) nxt = random_instr();
    end else begin
      v_nxt   = 1'b0;
      fl_nxt  = 1'b0;
      flu_nxt = 1'b1;
      lsu_nxt = 1'b1;
      ack_nxt = 1'b1;
    end
    @(posedge clk_i);
    flush_i               <= fl_nxt;
    decoded_instr_valid_i <= v_nxt;
    decoded_instr_i       <= nxt;
    flu_ready_i           <= flu_nxt;
    lsu_ready_i           <= lsu_nxt;
    wb_i                  <= wb_nxt;
    commit_ack_i          <= ack_nxt;
  endtask

  initial begin
    seed                  = 32'h7333;
    cyc                   = '0;
    pc_cnt                = 32'h0000_1000;
    n_disp                = 0;
    n_commits             = 0;
    tail                  = '0;
    {issue_prev, flush_prev} = '0;
    for (int i = 0; i < issue_pkg::NR_REGS; i++) arch[i] = '0;
    arst_n_i              = 1'b0;
    flush_i               = 1'b0;
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    flu_ready_i           = 1'b0;
    lsu_ready_i           = 1'b0;
    wb_i                  = '0;
    commit_ack_i          = 1'b0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    // Reset state of the dispatch registers
    assert (fu_data_o == '0) else plain_error("dispatch payload not cleared by reset");
    for (int n = 0; n < NUM_CYCLES; n++) run_cycle(1'b1);
    // Drain outstanding work, bounded
    for (int t = 0; (t < DRAIN_LIMIT) && ((model_q.size() != 0) || (pend_q.size() != 0));
         t++) begin
      run_cycle(1'b0);
    end
    assert (model_q.size() == 0) else plain_error("instructions never committed before timeout");
    assert (n_commits > 100) else plain_error("too few instructions committed");
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
/*
 * Free-running testbench clock, 4 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  // Half period of 2 ns
  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
/*
 * Issue stage top, scoreboard plus operand read and dispatch
 */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       flush_i,
  // Decode handshake
  input  wire issue_pkg::decoded_instr_t  decoded_instr_i,
  input  wire logic                       decoded_instr_valid_i,
  output logic                            decoded_instr_ack_o,
  output logic                            sb_full_o,
  // Functional units
  output issue_pkg::fu_data_t             fu_data_o,
  output logic                            alu_valid_o,
  output logic                            lsu_valid_o,
  output logic                            mul_valid_o,
  input  wire logic                       flu_ready_i,
  input  wire logic                       lsu_ready_i,
  input  wire issue_pkg::wb_t             wb_i,
  // Commit port
  output issue_pkg::commit_t              commit_o,
  output logic                            commit_valid_o,
  input  wire logic                       commit_ack_i,
  output logic                            stall_issue_o
);

  // ------------------------------
  // Scoreboard to operand read
  // ------------------------------
  issue_pkg::decoded_instr_t issue_instr_sb_iro;
  issue_pkg::trans_id_t      issue_trans_id_sb_iro;
  logic                      issue_valid_sb_iro;
  logic                      issue_ack_iro_sb;
  issue_pkg::fwd_t           fwd_sb_iro;
  issue_pkg::rf_write_t      rf_write_sb_iro;

  issue_scoreboard i_issue_scoreboard (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .flush_i               (flush_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .sb_full_o             (sb_full_o),
    .issue_instr_o         (issue_instr_sb_iro),
    .issue_trans_id_o      (issue_trans_id_sb_iro),
    .issue_valid_o         (issue_valid_sb_iro),
    .issue_ack_i           (issue_ack_iro_sb),
    .fwd_o                 (fwd_sb_iro),
    .wb_i                  (wb_i),
    .commit_o              (commit_o),
    .commit_valid_o        (commit_valid_o),
    .commit_ack_i          (commit_ack_i),
    .rf_write_o            (rf_write_sb_iro)
  );

  // Flush also cancels the pending dispatch
  issue_read_operands i_issue_read_operands (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .flush_i          (flush_i),
    .issue_instr_i    (issue_instr_sb_iro),
    .issue_trans_id_i (issue_trans_id_sb_iro),
    .issue_valid_i    (issue_valid_sb_iro),
    .issue_ack_o      (issue_ack_iro_sb),
    .fwd_i            (fwd_sb_iro),
    .rf_write_i       (rf_write_sb_iro),
    .flu_ready_i      (flu_ready_i),
    .lsu_ready_i      (lsu_ready_i),
    .fu_data_o        (fu_data_o),
    .alu_valid_o      (alu_valid_o),
    .lsu_valid_o      (lsu_valid_o),
    .mul_valid_o      (mul_valid_o),
    .stall_issue_o    (stall_issue_o)
  );

endmodule

`default_nettype wire

// File: logic/issue_read_operands.sv
/*
 * Hazard check and operand fetch with scoreboard forwarding
 * Registered dispatch to ALU, LSU and multiplier, holds the register file
 */
`timescale 1ns/1ps
`default_nettype none

module issue_read_operands (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       flush_i,
  input  wire issue_pkg::decoded_instr_t  issue_instr_i,
  input  wire issue_pkg::trans_id_t       issue_trans_id_i,
  input  wire logic                       issue_valid_i,
  output logic                            issue_ack_o,
  input  wire issue_pkg::fwd_t            fwd_i,
  input  wire issue_pkg::rf_write_t       rf_write_i,
  input  wire logic                       flu_ready_i,
  input  wire logic                       lsu_ready_i,
  output issue_pkg::fu_data_t             fu_data_o,
  output logic                            alu_valid_o,
  output logic                            lsu_valid_o,
  output logic                            mul_valid_o,
  output logic                            stall_issue_o
);

  logic [issue_pkg::XLEN-1:0] rf_a, rf_b;
  logic [issue_pkg::XLEN-1:0] fwd_a, fwd_b;
  logic [issue_pkg::XLEN-1:0] operand_a, operand_b;
  logic hit_a, hit_b, rdy_a, rdy_b;
  logic hazard;
  logic fu_ready;

  // Youngest issued producer of rs, walking from the head towards issue
  function automatic void find_producer(
    input  issue_pkg::reg_addr_t        rs,
    input  issue_pkg::fwd_t             fwd,
    output logic                        hit,
    output logic                        ready,
    output logic [issue_pkg::XLEN-1:0]  value
  );
    issue_pkg::trans_id_t idx;
    hit   = 1'b0;
    ready = 1'b0;
    value = '0;
    for (int k = 0; k < issue_pkg::NR_SB_ENTRIES; k++) begin
      idx = fwd.commit_pointer + issue_pkg::trans_id_t'(k);
      // Later matches are younger and override
      if (fwd.issued[idx] && (rs != '0) && (fwd.rd[idx] == rs)) begin
        hit   = 1'b1;
        ready = fwd.done[idx];
        value = fwd.result[idx];
      end
    end
  endfunction

  issue_regfile i_issue_regfile (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (issue_instr_i.rs1),
    .raddr_b_i (issue_instr_i.rs2),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .wr_i      (rf_write_i)
  );

  // ------------------------------
  // Operand select and hazards
  // ------------------------------
  always_comb begin
    find_producer(issue_instr_i.rs1, fwd_i, hit_a, rdy_a, fwd_a);
    find_producer(issue_instr_i.rs2, fwd_i, hit_b, rdy_b, fwd_b);
  end

  assign operand_a = hit_a ? fwd_a : rf_a;
  assign operand_b = issue_instr_i.use_imm ? issue_instr_i.imm
                   : (hit_b ? fwd_b : rf_b);

  // rs2 is not read when imm replaces it
  assign hazard = (hit_a & ~rdy_a) | (hit_b & ~rdy_b & ~issue_instr_i.use_imm);

  // LSU has its own ready, ALU and multiplier share one
  assign fu_ready = (issue_instr_i.fu == issue_pkg::FU_LSU) ? lsu_ready_i : flu_ready_i;

  assign issue_ack_o   = issue_valid_i & ~hazard & fu_ready & ~flush_i;
  assign stall_issue_o = issue_valid_i & ~issue_ack_o;

  // ------------------------------
  // Dispatch registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fu_data_o   <= '0;
      alu_valid_o <= 1'b0;
      lsu_valid_o <= 1'b0;
      mul_valid_o <= 1'b0;
    end else begin
      // One-cycle pulses, ack is already low during a flush
      alu_valid_o <= issue_ack_o & (issue_instr_i.fu == issue_pkg::FU_ALU);
      lsu_valid_o <= issue_ack_o & (issue_instr_i.fu == issue_pkg::FU_LSU);
      mul_valid_o <= issue_ack_o & (issue_instr_i.fu == issue_pkg::FU_MUL);
      if (issue_ack_o) begin
        fu_data_o.fu        <= issue_instr_i.fu;
        fu_data_o.op        <= issue_instr_i.op;
        fu_data_o.operand_a <= operand_a;
        fu_data_o.operand_b <= operand_b;
        fu_data_o.imm       <= issue_instr_i.imm;
        fu_data_o.trans_id  <= issue_trans_id_i;
        fu_data_o.pc        <= issue_instr_i.pc;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/issue_scoreboard.sv
/*
 * Four-entry circular scoreboard with decode accept and in-order issue
 * Out-of-order writeback marking, in-order commit and register file retire
 */
`timescale 1ns/1ps
`default_nettype none

module issue_scoreboard (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       flush_i,
  // Decode side
  input  wire issue_pkg::decoded_instr_t  decoded_instr_i,
  input  wire logic                       decoded_instr_valid_i,
  output logic                            decoded_instr_ack_o,
  output logic                            sb_full_o,
  // Towards operand read
  output issue_pkg::decoded_instr_t       issue_instr_o,
  output issue_pkg::trans_id_t            issue_trans_id_o,
  output logic                            issue_valid_o,
  input  wire logic                       issue_ack_i,
  output issue_pkg::fwd_t                 fwd_o,
  // Writeback and commit
  input  wire issue_pkg::wb_t             wb_i,
  output issue_pkg::commit_t              commit_o,
  output logic                            commit_valid_o,
  input  wire logic                       commit_ack_i,
  output issue_pkg::rf_write_t            rf_write_o
);

  localparam int unsigned N = issue_pkg::NR_SB_ENTRIES;

  // Entry payload
  issue_pkg::decoded_instr_t  mem_q    [N];
  logic [issue_pkg::XLEN-1:0] result_q [N];

  // Entry state
  logic [N-1:0] occupied_q;
  logic [N-1:0] issued_q;
  logic [N-1:0] done_q;

  issue_pkg::trans_id_t tail_q;
  issue_pkg::trans_id_t issue_q;
  issue_pkg::trans_id_t commit_q;
  logic [issue_pkg::TRANS_ID_BITS:0] cnt_q;

  logic full;
  logic accept;
  logic issue_fire;
  logic wb_hit;
  logic commit_fire;

  // ------------------------------
  // Handshakes
  // ------------------------------
  assign full                = (cnt_q == N);
  assign sb_full_o           = full;
  // Ack only depends on occupancy
  assign decoded_instr_ack_o = ~full;
  assign accept              = decoded_instr_valid_i & ~full;

  assign issue_instr_o    = mem_q[issue_q];
  assign issue_trans_id_o = issue_q;
  assign issue_valid_o    = occupied_q[issue_q] & ~issued_q[issue_q];
  assign issue_fire       = issue_valid_o & issue_ack_i;

  // Late results for cancelled or free slots are ignored
  assign wb_hit = wb_i.valid & occupied_q[wb_i.trans_id] & issued_q[wb_i.trans_id];

  assign commit_valid_o = occupied_q[commit_q] & done_q[commit_q];
  assign commit_fire    = commit_valid_o & commit_ack_i;

  assign commit_o.trans_id = commit_q;
  assign commit_o.pc       = mem_q[commit_q].pc;
  assign commit_o.rd       = mem_q[commit_q].rd;
  assign commit_o.result   = result_q[commit_q];

  // Retire write lands on the same edge as the commit ack
  assign rf_write_o.we    = commit_fire & (mem_q[commit_q].rd != '0);
  assign rf_write_o.waddr = mem_q[commit_q].rd;
  assign rf_write_o.wdata = result_q[commit_q];

  // Forwarding view
  assign fwd_o.commit_pointer = commit_q;
  assign fwd_o.issue_pointer  = issue_q;
  assign fwd_o.issued         = issued_q;
  assign fwd_o.done           = done_q;
  always_comb begin
    for (int i = 0; i < N; i++) begin
      fwd_o.rd[i]     = mem_q[i].rd;
      fwd_o.result[i] = result_q[i];
    end
  end

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      occupied_q <= '0;
      issued_q   <= '0;
      done_q     <= '0;
      tail_q     <= '0;
      issue_q    <= '0;
      commit_q   <= '0;
      cnt_q      <= '0;
    end else if (flush_i) begin
      // Whole buffer dropped, decode accept in this cycle too
      occupied_q <= '0;
      issued_q   <= '0;
      done_q     <= '0;
      tail_q     <= '0;
      issue_q    <= '0;
      commit_q   <= '0;
      cnt_q      <= '0;
    end else begin
      if (accept) begin
        occupied_q[tail_q] <= 1'b1;
        issued_q[tail_q]   <= 1'b0;
        done_q[tail_q]     <= 1'b0;
        tail_q             <= tail_q + 1'b1;
      end
      if (issue_fire) begin
        issued_q[issue_q] <= 1'b1;
        issue_q           <= issue_q + 1'b1;
      end
      if (wb_hit) begin
        done_q[wb_i.trans_id] <= 1'b1;
      end
      if (commit_fire) begin
        occupied_q[commit_q] <= 1'b0;
        issued_q[commit_q]   <= 1'b0;
        done_q[commit_q]     <= 1'b0;
        commit_q             <= commit_q + 1'b1;
      end
      cnt_q <= cnt_q + {{issue_pkg::TRANS_ID_BITS{1'b0}}, accept}
                     - {{issue_pkg::TRANS_ID_BITS{1'b0}}, commit_fire};
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[tail_q] <= decoded_instr_i;
    end
    if (wb_hit) begin
      result_q[wb_i.trans_id] <= wb_i.data;
    end
  end

endmodule

`default_nettype wire

// File: logic/issue_regfile.sv
/*
 * Architectural register file, two combinational read ports
 * One write port, register zero hardwired to zero
 */
`timescale 1ns/1ps
`default_nettype none

module issue_regfile (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire issue_pkg::reg_addr_t       raddr_a_i,
  input  wire issue_pkg::reg_addr_t       raddr_b_i,
  output logic [issue_pkg::XLEN-1:0]      rdata_a_o,
  output logic [issue_pkg::XLEN-1:0]      rdata_b_o,
  input  wire issue_pkg::rf_write_t       wr_i
);

  // Register zero has no storage
  logic [issue_pkg::XLEN-1:0] regs_q [1:issue_pkg::NR_REGS-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < issue_pkg::NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we && (wr_i.waddr != '0)) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Reads see the old value during a write cycle
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: logic/issue_pkg.sv
/*
 * Shared widths, register and scoreboard sizes for the issue stage
 * Functional-unit encoding and the packed structs passed between blocks
 */
`default_nettype none

package issue_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int unsigned NR_REGS       = 16;
  localparam int unsigned REG_ADDR_BITS = 4;
  localparam int unsigned XLEN          = 32;
  localparam int unsigned NR_SB_ENTRIES = 4;
  localparam int unsigned TRANS_ID_BITS = 2;

  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

  // Target functional unit, code 3 is unused
  typedef enum logic [1:0] {
    FU_ALU = 2'd0,
    FU_LSU = 2'd1,
    FU_MUL = 2'd2
  } fu_t;

  // ------------------------------
  // Stage payloads
  // ------------------------------
  // Instruction as handed over by decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    fu_t             fu;
    logic [3:0]      op;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    reg_addr_t       rd;
    logic [XLEN-1:0] imm;
    logic            use_imm;   // Operand b comes from imm
  } decoded_instr_t;

  // Dispatch payload towards ALU, LSU or multiplier
  typedef struct packed {
    fu_t             fu;
    logic [3:0]      op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] imm;
    trans_id_t       trans_id;
    logic [XLEN-1:0] pc;
  } fu_data_t;

  // Result returning from a functional unit
  typedef struct packed {
    logic            valid;
    trans_id_t       trans_id;
    logic [XLEN-1:0] data;
  } wb_t;

  // Head of the scoreboard offered for commit
  typedef struct packed {
    trans_id_t       trans_id;
    logic [XLEN-1:0] pc;
    reg_addr_t       rd;
    logic [XLEN-1:0] result;
  } commit_t;

  // Single register file write port
  typedef struct packed {
    logic            we;
    reg_addr_t       waddr;
    logic [XLEN-1:0] wdata;
  } rf_write_t;

  // Scoreboard view used for hazard checks and forwarding
  typedef struct packed {
    trans_id_t                                commit_pointer;
    trans_id_t                                issue_pointer;
    logic [NR_SB_ENTRIES-1:0]                 issued;
    logic [NR_SB_ENTRIES-1:0]                 done;
    logic [NR_SB_ENTRIES-1:0][REG_ADDR_BITS-1:0] rd;
    logic [NR_SB_ENTRIES-1:0][XLEN-1:0]       result;
  } fwd_t;

endpackage

`default_nettype wire
